//--- verilog/pcw_params.svh
// Shared constants for the PCW system-control block
// I/O port numbers, address widths, paging reset values
// and the timer clear delay after a status read

`ifndef PCW_PARAMS_SVH
`define PCW_PARAMS_SVH

// Paging registers, one per 16K slot, then the CPC read lock
`define PCW_PORT_F0 8'hF0
`define PCW_PORT_F1 8'hF1
`define PCW_PORT_F2 8'hF2
`define PCW_PORT_F3 8'hF3
`define PCW_PORT_F4 8'hF4
// System control register, also the status read port
`define PCW_PORT_F8 8'hF8

// Address widths
`define PCW_CPU_ADDR_W 16
`define PCW_RAM_ADDR_W 18
`define PCW_OFFSET_W   14

// Power-up paging, PCW mode with banks 0 to 3 in order
`define PCW_PAGE_RESET_0 8'h80
`define PCW_PAGE_RESET_1 8'h81
`define PCW_PAGE_RESET_2 8'h82
`define PCW_PAGE_RESET_3 8'h83
`define PCW_LOCK_RESET   8'hF1

// Cycles from a port F4 read until the timer state clears
`define PCW_TIMER_CLEAR_CYCLES 32
`define PCW_MISS_W             4

`endif

//--- verilog/pcw_pkg.sv
// Types shared by the PCW system-control modules
// Paging register layout, the full page set, disk interrupt
// routing flags, F8 command codes and the RAM address type

`include "pcw_params.svh"

package pcw_pkg;

    // One paging register as written to F0..F3
    // In PCW mode the bank is {bank_hi, bank_lo}
    typedef struct packed {
        logic       pcw_mode;
        logic [2:0] cpc_rd_bank;
        logic       bank_hi;
        logic [2:0] bank_lo;
    } page_reg_t;

    // Four slot registers plus the CPC read lock (40 bits)
    typedef struct packed {
        page_reg_t [3:0] page;
        logic [7:0]      lock;
    } page_set_t;

    // Where disk interrupts go, with a one-cycle pulse on change
    typedef struct packed {
        logic to_nmi;
        logic to_int;
        logic mode_change;
    } disk_route_t;

    // Low nibble of a write to F8
    typedef enum logic [3:0] {
        BOOT_END  = 4'd0,
        DISK_NMI  = 4'd2,
        DISK_INT  = 4'd3,
        DISK_OFF  = 4'd4,
        TC_SET    = 4'd5,
        TC_CLR    = 4'd6,
        MOTOR_ON  = 4'd9,
        MOTOR_OFF = 4'd10,
        SPK_ON    = 4'd11,
        SPK_OFF   = 4'd12
    } sys_cmd_e;

    typedef logic [`PCW_RAM_ADDR_W-1:0] ram_addr_t;

endpackage

//--- verilog/io_bus_if.sv
// Decoded Z80 I/O cycle as seen by the register blocks
// One strobe cycle is one access, there is no handshake

`timescale 1ns/100ps

interface io_bus_if;

    // Write strobe, active high
    logic       wr;
    // Read strobe, active high
    logic       rd;
    // Low byte of the CPU address during the I/O cycle
    logic [7:0] port;
    // CPU data out
    logic [7:0] wdata;

    // Register blocks only listen
    modport target (
        input wr,
        input rd,
        input port,
        input wdata
    );

endinterface

//--- verilog/page_regs.sv
// Memory paging register file
// Four slot registers at F0..F3 and the CPC read lock at F4
// Loads on an I/O write, back to power-up paging on reset

`timescale 1ns/100ps

`include "pcw_params.svh"

module page_regs (
    input  logic                clk_sys,
    input  logic                reset,
    io_bus_if.target            bus,
    output pcw_pkg::page_set_t  pages
);

    // One load enable per register, lock is bit 4
    logic [4:0] load_en;

    always_comb
    begin
        load_en = '0;
        if (bus.wr)
        begin
            case (bus.port)
                `PCW_PORT_F0: load_en[0] = 1'b1;
                `PCW_PORT_F1: load_en[1] = 1'b1;
                `PCW_PORT_F2: load_en[2] = 1'b1;
                `PCW_PORT_F3: load_en[3] = 1'b1;
                `PCW_PORT_F4: load_en[4] = 1'b1;
                default:      load_en    = '0;
            endcase
        end
    end

    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            pages.page[0] <= pcw_pkg::page_reg_t'(`PCW_PAGE_RESET_0);
            pages.page[1] <= pcw_pkg::page_reg_t'(`PCW_PAGE_RESET_1);
            pages.page[2] <= pcw_pkg::page_reg_t'(`PCW_PAGE_RESET_2);
            pages.page[3] <= pcw_pkg::page_reg_t'(`PCW_PAGE_RESET_3);
            pages.lock    <= `PCW_LOCK_RESET;
        end
        else
        begin
            for (int i = 0; i < 4; i++)
            begin
                if (load_en[i])
                    pages.page[i] <= pcw_pkg::page_reg_t'(bus.wdata);
            end
            // Lock bits 7..4 belong to slots 3..0
            if (load_en[4])
                pages.lock <= bus.wdata;
        end
    end

    // A single I/O cycle changes at most one register
    a_single_load: assert property (@(posedge clk_sys) disable iff (reset)
        $onehot0({pages.lock    !== $past(pages.lock),
                  pages.page[3] !== $past(pages.page[3]),
                  pages.page[2] !== $past(pages.page[2]),
                  pages.page[1] !== $past(pages.page[1]),
                  pages.page[0] !== $past(pages.page[0])}))
        else $error("page_regs: more than one paging register loaded");

endmodule

//--- verilog/sys_ctrl_reg.sv
// System control register at port F8
// Decodes the command nibble into disk interrupt routing,
// FDC terminal count, motor and speaker enable

`timescale 1ns/100ps

`include "pcw_params.svh"

module sys_ctrl_reg (
    input  logic                 clk_sys,
    input  logic                 reset,
    io_bus_if.target             bus,
    output pcw_pkg::disk_route_t route,
    output logic                 tc,
    output logic                 motor,
    output logic                 speaker_enable
);

    pcw_pkg::sys_cmd_e cmd;
    logic              cmd_wr;

    // Only the low nibble carries the command
    assign cmd    = pcw_pkg::sys_cmd_e'(bus.wdata[3:0]);
    assign cmd_wr = bus.wr && (bus.port == `PCW_PORT_F8);

    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            route          <= '0;
            tc             <= 1'b0;
            motor          <= 1'b0;
            speaker_enable <= 1'b0;
        end
        else
        begin
            // Mode change is a single-cycle pulse
            route.mode_change <= 1'b0;
            if (cmd_wr)
            begin
                case (cmd)
                    // Switching to NMI does not pulse mode_change
                    pcw_pkg::DISK_NMI:
                    begin
                        route.to_nmi <= 1'b1;
                        route.to_int <= 1'b0;
                    end
                    pcw_pkg::DISK_INT:
                    begin
                        route.to_nmi      <= 1'b0;
                        route.to_int      <= 1'b1;
                        route.mode_change <= 1'b1;
                    end
                    // Disk interrupt disconnected from both lines
                    pcw_pkg::DISK_OFF:
                    begin
                        route.to_nmi      <= 1'b0;
                        route.to_int      <= 1'b0;
                        route.mode_change <= 1'b1;
                    end
                    pcw_pkg::TC_SET:    tc             <= 1'b1;
                    pcw_pkg::TC_CLR:    tc             <= 1'b0;
                    pcw_pkg::MOTOR_ON:  motor          <= 1'b1;
                    pcw_pkg::MOTOR_OFF: motor          <= 1'b0;
                    pcw_pkg::SPK_ON:    speaker_enable <= 1'b1;
                    pcw_pkg::SPK_OFF:   speaker_enable <= 1'b0;
                    // BOOT_END and unused codes leave state alone
                    default:            route.mode_change <= 1'b0;
                endcase
            end
        end
    end

    // Disk interrupt goes to one line at most
    a_route_exclusive: assert property (@(posedge clk_sys) disable iff (reset)
        !(route.to_nmi && route.to_int))
        else $error("sys_ctrl_reg: disk routed to both NMI and INT");

endmodule

//--- verilog/mem_mapper.sv
// Combinational bank mapper from CPU address to RAM address
// PCW mode uses a 4-bit bank, CPC mode a 3-bit bank with
// separate read and write banks and a per-slot read lock

`timescale 1ns/100ps

`include "pcw_params.svh"

module mem_mapper (
    input  logic [`PCW_CPU_ADDR_W-1:0] cpu_addr,
    input  logic                       mem_wr,
    input  pcw_pkg::page_set_t         pages,
    output pcw_pkg::ram_addr_t         ram_addr
);

    logic [1:0]               slot;
    logic [`PCW_OFFSET_W-1:0] offset;
    pcw_pkg::page_reg_t       sel;
    logic                     rd_locked;
    logic [2:0]               cpc_bank;

    // Top two address bits pick the 16K slot
    assign slot   = cpu_addr[`PCW_CPU_ADDR_W-1 -: 2];
    assign offset = cpu_addr[`PCW_OFFSET_W-1:0];
    assign sel    = pages.page[slot];

    // Lock bit 4 + slot forces reads onto the write bank
    assign rd_locked = pages.lock[{1'b1, slot}];

    always_comb
    begin
        if (mem_wr || rd_locked)
            cpc_bank = sel.bank_lo;
        else
            cpc_bank = sel.cpc_rd_bank;
    end

    always_comb
    begin
        if (sel.pcw_mode)
        begin
            // Full 256K reach
            ram_addr = {sel.bank_hi, sel.bank_lo, offset};
        end
        else
        begin
            // CPC banks live in the low 128K
            ram_addr = {1'b0, cpc_bank, offset};
        end
    end

endmodule

//--- verilog/int_ctrl.sv
// Interrupt controller and status readback
// 300 Hz timer edge handling with miss counter and delayed clear,
// FDC status latch, NMI flag, INT and NMI line generation
// Status byte on reads of F4 and F8, FF elsewhere

`timescale 1ns/100ps

`include "pcw_params.svh"

module int_ctrl (
    input  logic                 clk_sys,
    input  logic                 reset,
    io_bus_if.target             bus,
    input  pcw_pkg::disk_route_t route,
    input  logic                 fdc_int,
    input  logic                 vid_timer,
    input  logic                 iff1,
    input  logic                 vblank,
    input  logic                 ntsc,
    output logic                 int_n,
    output logic                 nmi_n,
    output logic [7:0]           io_rdata
);

    localparam int CLR_W = $clog2(`PCW_TIMER_CLEAR_CYCLES);

    // Input sync and edge history
    logic fdc_sync, fdc_prev;
    logic timer_sync, timer_prev;
    logic fdc_pe, fdc_ne, timer_pe;

    logic                   fdc_latch;
    logic                   nmi_flag;
    logic                   timer_line;
    logic                   int_line;
    logic                   nmi_line;
    logic [`PCW_MISS_W-1:0] misses;
    logic                   clear_run;
    logic [CLR_W-1:0]       clear_cnt;
    logic                   status_rd;

    assign fdc_pe   = fdc_sync & ~fdc_prev;
    assign fdc_ne   = ~fdc_sync & fdc_prev;
    assign timer_pe = timer_sync & ~timer_prev;

    // A status read at F4 starts the timer clear
    assign status_rd = bus.rd && (bus.port == `PCW_PORT_F4);

    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            fdc_sync   <= 1'b0;
            fdc_prev   <= 1'b0;
            timer_sync <= 1'b0;
            timer_prev <= 1'b0;
            fdc_latch  <= 1'b0;
            nmi_flag   <= 1'b0;
            timer_line <= 1'b0;
            int_line   <= 1'b0;
            nmi_line   <= 1'b0;
            misses     <= '0;
            clear_run  <= 1'b0;
            clear_cnt  <= '0;
        end
        else
        begin
            fdc_sync   <= fdc_int;
            fdc_prev   <= fdc_sync;
            timer_sync <= vid_timer;
            timer_prev <= timer_sync;

            // FDC latch follows the interrupt edges
            if (fdc_pe)
            begin
                fdc_latch <= 1'b1;
                if (route.to_nmi)
                    nmi_flag <= 1'b1;
            end
            else if (fdc_ne)
                fdc_latch <= 1'b0;

            // Lines are only re-evaluated on the timer tick
            if (timer_pe)
            begin
                if (!(&misses))
                    misses <= misses + 1'b1;
                timer_line <= iff1;
                nmi_line   <= nmi_flag;
                int_line   <= route.to_int & fdc_latch & iff1;
            end

            // Restart the delay on every F4 read
            if (status_rd)
            begin
                clear_run <= 1'b1;
                clear_cnt <= '0;
            end
            else if (clear_run)
            begin
                if (clear_cnt == CLR_W'(`PCW_TIMER_CLEAR_CYCLES - 1))
                begin
                    clear_run  <= 1'b0;
                    timer_line <= 1'b0;
                    misses     <= '0;
                end
                else
                    clear_cnt <= clear_cnt + 1'b1;
            end

            // Routing change drops the line no longer in use
            if (route.mode_change)
            begin
                if (route.to_nmi)
                    int_line <= 1'b0;
                else if (route.to_int)
                    nmi_flag <= 1'b0;
                else
                begin
                    nmi_flag <= 1'b0;
                    int_line <= 1'b0;
                end
            end
        end
    end

    // Timer and disk share the INT pin
    assign int_n = ~(timer_line | int_line);
    assign nmi_n = ~nmi_line;

    always_comb
    begin
        if (bus.port == `PCW_PORT_F4 || bus.port == `PCW_PORT_F8)
            io_rdata = {1'b0, vblank, fdc_latch, ~ntsc, misses};
        else
            io_rdata = 8'hFF;
    end

    // Clear delay ends a fixed number of cycles after the last F4 read
    a_clear_after_delay: assert property (@(posedge clk_sys) disable iff (reset)
        $fell(clear_run) && !$past(reset)
            |-> $past(status_rd, `PCW_TIMER_CLEAR_CYCLES + 1))
        else $error("int_ctrl: timer clear ended without a matching F4 read");

endmodule

//--- verilog/pcw_sys_ctrl.sv
// System-control top level
// Drives the I/O bus interface from the CPU strobes and connects
// the paging registers, bank mapper, control register and
// interrupt controller

`timescale 1ns/100ps

`include "pcw_params.svh"

module pcw_sys_ctrl (
    input  logic                       clk_sys,
    input  logic                       reset,
    input  logic                       io_wr,
    input  logic                       io_rd,
    input  logic [7:0]                 io_port,
    input  logic [7:0]                 io_wdata,
    input  logic [`PCW_CPU_ADDR_W-1:0] cpu_addr,
    input  logic                       mem_wr,
    input  logic                       fdc_int,
    input  logic                       vid_timer,
    input  logic                       iff1,
    input  logic                       vblank,
    input  logic                       ntsc,
    output pcw_pkg::ram_addr_t         ram_addr,
    output logic [7:0]                 io_rdata,
    output logic                       int_n,
    output logic                       nmi_n,
    output logic                       tc,
    output logic                       motor,
    output logic                       speaker_enable
);

    pcw_pkg::page_set_t   pages;
    pcw_pkg::disk_route_t route;

    io_bus_if bus_if ();

    assign bus_if.wr    = io_wr;
    assign bus_if.rd    = io_rd;
    assign bus_if.port  = io_port;
    assign bus_if.wdata = io_wdata;

    page_regs page_regs_i (
        .clk_sys (clk_sys),
        .reset   (reset),
        .bus     (bus_if.target),
        .pages   (pages)
    );

    mem_mapper mem_mapper_i (
        .cpu_addr (cpu_addr),
        .mem_wr   (mem_wr),
        .pages    (pages),
        .ram_addr (ram_addr)
    );

    sys_ctrl_reg sys_ctrl_reg_i (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .bus            (bus_if.target),
        .route          (route),
        .tc             (tc),
        .motor          (motor),
        .speaker_enable (speaker_enable)
    );

    int_ctrl int_ctrl_i (
        .clk_sys   (clk_sys),
        .reset     (reset),
        .bus       (bus_if.target),
        .route     (route),
        .fdc_int   (fdc_int),
        .vid_timer (vid_timer),
        .iff1      (iff1),
        .vblank    (vblank),
        .ntsc      (ntsc),
        .int_n     (int_n),
        .nmi_n     (nmi_n),
        .io_rdata  (io_rdata)
    );

endmodule

//--- test/pcw_sys_ctrl_checks.svh
// Testbench helpers for the system-control block
// Reference models for bank mapping and the status byte,
// I/O bus driver tasks and typed compare tasks

`ifndef PCW_SYS_CTRL_CHECKS_SVH
`define PCW_SYS_CTRL_CHECKS_SVH

// Shadow of the paging registers as last written
logic [7:0] shadow_page [4];
logic [7:0] shadow_lock;

// Expected RAM address from the PCW and CPC paging rules
function automatic pcw_pkg::ram_addr_t expected_ram_addr(input logic [15:0] addr,
                                                         input logic wr);
    logic [1:0] slot;
    logic [7:0] page;
    logic [3:0] read_lock;
    logic [2:0] bank;
    slot      = addr[15:14];
    page      = shadow_page[slot];
    read_lock = shadow_lock[7:4];
    // PCW mode reaches all 16 banks
    if (page[7])
        return {page[3:0], addr[13:0]};
    // Locked slots read from the write bank
    if (wr || read_lock[slot])
        bank = page[2:0];
    else
        bank = page[6:4];
    return {1'b0, bank, addr[13:0]};
endfunction

// Status byte, bit 7 down to bit 0
function automatic logic [7:0] expected_status(input logic vb, input logic latch,
                                               input logic nt, input logic [3:0] misses);
    return {1'b0, vb, latch, ~nt, misses};
endfunction

task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "Simulation stopped at first error");
endtask

task automatic check_ram_addr(input pcw_pkg::ram_addr_t expected,
                              input pcw_pkg::ram_addr_t actual);
    if (actual !== expected)
        report_failure($sformatf("Error %s: ram_addr expected %h actual %h",
                                 test_name, expected, actual));
endtask

task automatic check_byte(input string what, input logic [7:0] expected,
                          input logic [7:0] actual);
    if (actual !== expected)
        report_failure($sformatf("Error %s: %s expected %h actual %h",
                                 test_name, what, expected, actual));
endtask

task automatic check_bit(input string what, input logic expected, input logic actual);
    if (actual !== expected)
        report_failure($sformatf("Error %s: %s expected %b actual %b",
                                 test_name, what, expected, actual));
endtask

// One write strobe, captured on the following rising edge
task automatic io_write(input logic [7:0] port, input logic [7:0] wdata);
    @(posedge clk_sys);
    #1;
    io_port  = port;
    io_wdata = wdata;
    io_wr    = 1'b1;
    @(posedge clk_sys);
    #1;
    io_wr = 1'b0;
endtask

// Read data is combinational, sampled mid-cycle
task automatic io_read(input logic [7:0] port, output logic [7:0] rdata);
    @(posedge clk_sys);
    #1;
    io_port = port;
    io_rd   = 1'b1;
    #2;
    rdata = io_rdata;
    @(posedge clk_sys);
    #1;
    io_rd = 1'b0;
endtask

`endif

//--- test/tb_pcw_sys_ctrl.sv
// Testbench for the PCW system-control block
// Clock, reset, DUT and the test sequence for paging,
// system commands, timer clear and disk interrupt routing

`timescale 1ns/100ps

`include "pcw_params.svh"

module tb_pcw_sys_ctrl;

    localparam int WAIT_LIMIT = 100;

    logic               clk_sys;
    logic               reset;
    logic               io_wr;
    logic               io_rd;
    logic [7:0]         io_port;
    logic [7:0]         io_wdata;
    logic [15:0]        cpu_addr;
    logic               mem_wr;
    logic               fdc_int;
    logic               vid_timer;
    logic               iff1;
    logic               vblank;
    logic               ntsc;
    pcw_pkg::ram_addr_t ram_addr;
    logic [7:0]         io_rdata;
    logic               int_n;
    logic               nmi_n;
    logic               tc;
    logic               motor;
    logic               speaker_enable;

    integer      seed = 32'hdb36;
    logic [31:0] rnd;
    logic [7:0]  data;
    // Expected miss counter, saturates at 15
    logic [3:0]  miss_model;
    string       test_name;

    `include "pcw_sys_ctrl_checks.svh"

    pcw_sys_ctrl dut_i (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .io_wr          (io_wr),
        .io_rd          (io_rd),
        .io_port        (io_port),
        .io_wdata       (io_wdata),
        .cpu_addr       (cpu_addr),
        .mem_wr         (mem_wr),
        .fdc_int        (fdc_int),
        .vid_timer      (vid_timer),
        .iff1           (iff1),
        .vblank         (vblank),
        .ntsc           (ntsc),
        .ram_addr       (ram_addr),
        .io_rdata       (io_rdata),
        .int_n          (int_n),
        .nmi_n          (nmi_n),
        .tc             (tc),
        .motor          (motor),
        .speaker_enable (speaker_enable)
    );

    initial
    begin
        clk_sys = 1'b0;
        forever #4 clk_sys = ~clk_sys;
    end

    // Mapper is combinational, compare once inputs settle
    task automatic probe_mapping(input logic [15:0] addr, input logic wr);
        @(posedge clk_sys);
        #1;
        cpu_addr = addr;
        mem_wr   = wr;
        #2;
        check_ram_addr(expected_ram_addr(addr, wr), ram_addr);
    endtask

    // Upper nibble is don't care
    task automatic send_cmd(input pcw_pkg::sys_cmd_e cmd);
        rnd = $random(seed);
        io_write(`PCW_PORT_F8, {rnd[7:4], cmd});
    endtask

    task automatic drive_fdc(input logic level);
        @(posedge clk_sys);
        #1;
        fdc_int = level;
    endtask

    // Two cycles high, then low long enough for the edge detector
    task automatic pulse_timer();
        @(posedge clk_sys);
        #1;
        vid_timer = 1'b1;
        repeat (2) @(posedge clk_sys);
        #1;
        vid_timer = 1'b0;
        repeat (3) @(posedge clk_sys);
        #1;
        if (miss_model != 4'hF)
            miss_model = miss_model + 4'd1;
    endtask

    // Poll int_n or nmi_n until it reaches the level
    task automatic wait_line(input logic on_nmi, input logic level, input string what);
        int   cycles;
        logic line;
        cycles = 0;
        line   = on_nmi ? nmi_n : int_n;
        while (line !== level && cycles < WAIT_LIMIT)
        begin
            @(posedge clk_sys);
            #1;
            cycles++;
            line = on_nmi ? nmi_n : int_n;
        end
        if (line !== level)
            report_failure($sformatf("Timed out in %s waiting for %s", test_name, what));
    endtask

    // Poll the F8 status byte, F8 reads leave the timer clear alone
    task automatic wait_status(input logic [7:0] expected);
        int         tries;
        logic [7:0] status;
        tries = 0;
        io_read(`PCW_PORT_F8, status);
        while (status !== expected && tries < WAIT_LIMIT)
        begin
            io_read(`PCW_PORT_F8, status);
            tries++;
        end
        if (status !== expected)
            report_failure($sformatf("Timed out in %s waiting for status %h, last read %h",
                                     test_name, expected, status));
    endtask

    initial
    begin
        reset      = 1'b1;
        io_wr      = 1'b0;
        io_rd      = 1'b0;
        io_port    = 8'h00;
        io_wdata   = 8'h00;
        cpu_addr   = 16'h0000;
        mem_wr     = 1'b0;
        fdc_int    = 1'b0;
        vid_timer  = 1'b0;
        iff1       = 1'b0;
        vblank     = 1'b1;
        ntsc       = 1'b0;
        miss_model = 4'd0;
        test_name  = "reset_state";
        shadow_page[0] = `PCW_PAGE_RESET_0;
        shadow_page[1] = `PCW_PAGE_RESET_1;
        shadow_page[2] = `PCW_PAGE_RESET_2;
        shadow_page[3] = `PCW_PAGE_RESET_3;
        shadow_lock    = `PCW_LOCK_RESET;
        repeat (2) @(posedge clk_sys);
        #1;
        reset = 1'b0;

        check_bit("int_n", 1'b1, int_n);
        check_bit("nmi_n", 1'b1, nmi_n);
        check_bit("tc", 1'b0, tc);
        check_bit("motor", 1'b0, motor);
        check_bit("speaker_enable", 1'b0, speaker_enable);
        // Power-up paging puts bank n in slot n
        for (int slot = 0; slot < 4; slot++)
        begin
            rnd = $random(seed);
            probe_mapping({2'(slot), rnd[13:0]}, rnd[14]);
        end
        io_read(`PCW_PORT_F0, data);
        check_byte("unused port read", 8'hFF, data);
        io_read(`PCW_PORT_F8, data);
        check_byte("status", expected_status(vblank, 1'b0, ntsc, miss_model), data);

        test_name = "pcw_paging";
        for (int i = 0; i < 4; i++)
        begin
            rnd = $random(seed);
            shadow_page[i] = rnd[7:0] | 8'h80;
            io_write(`PCW_PORT_F0 + 8'(i), shadow_page[i]);
        end
        for (int n = 0; n < 200; n++)
        begin
            rnd = $random(seed);
            probe_mapping(rnd[15:0], rnd[16]);
        end

        test_name = "cpc_paging";
        for (int i = 0; i < 4; i++)
        begin
            rnd = $random(seed);
            shadow_page[i] = rnd[7:0] & 8'h7F;
            io_write(`PCW_PORT_F0 + 8'(i), shadow_page[i]);
        end
        rnd = $random(seed);
        shadow_lock = rnd[7:0];
        io_write(`PCW_PORT_F4, shadow_lock);
        for (int n = 0; n < 200; n++)
        begin
            rnd = $random(seed);
            probe_mapping(rnd[15:0], rnd[16]);
        end

        test_name = "system_commands";
        send_cmd(pcw_pkg::TC_SET);
        check_bit("tc", 1'b1, tc);
        send_cmd(pcw_pkg::TC_CLR);
        check_bit("tc", 1'b0, tc);
        send_cmd(pcw_pkg::MOTOR_ON);
        check_bit("motor", 1'b1, motor);
        send_cmd(pcw_pkg::MOTOR_OFF);
        check_bit("motor", 1'b0, motor);
        send_cmd(pcw_pkg::SPK_ON);
        check_bit("speaker_enable", 1'b1, speaker_enable);
        send_cmd(pcw_pkg::SPK_OFF);
        check_bit("speaker_enable", 1'b0, speaker_enable);

        test_name = "timer_clear";
        iff1 = 1'b1;
        repeat (18) pulse_timer();
        wait_line(1'b0, 1'b0, "int_n low after timer ticks");
        wait_status(expected_status(vblank, 1'b0, ntsc, miss_model));
        // F4 read returns the status and starts the delayed clear
        io_read(`PCW_PORT_F4, data);
        check_byte("status at F4", expected_status(vblank, 1'b0, ntsc, miss_model), data);
        miss_model = 4'd0;
        wait_line(1'b0, 1'b1, "int_n release after F4 read");
        wait_status(expected_status(vblank, 1'b0, ntsc, miss_model));

        test_name = "disk_routing";
        iff1 = 1'b0;
        send_cmd(pcw_pkg::DISK_NMI);
        drive_fdc(1'b1);
        wait_status(expected_status(vblank, 1'b1, ntsc, miss_model));
        pulse_timer();
        wait_line(1'b1, 1'b0, "nmi_n low with disk routed to NMI");
        check_bit("int_n", 1'b1, int_n);
        drive_fdc(1'b0);
        wait_status(expected_status(vblank, 1'b0, ntsc, miss_model));
        // Disconnecting the disk drops the NMI flag
        send_cmd(pcw_pkg::DISK_OFF);
        pulse_timer();
        wait_line(1'b1, 1'b1, "nmi_n high after DISK_OFF");
        iff1 = 1'b1;
        send_cmd(pcw_pkg::DISK_INT);
        drive_fdc(1'b1);
        wait_status(expected_status(vblank, 1'b1, ntsc, miss_model));
        pulse_timer();
        wait_line(1'b0, 1'b0, "int_n low with disk routed to INT");
        check_bit("nmi_n", 1'b1, nmi_n);
        // Timer part cleared, the disk INT line alone keeps int_n low
        io_read(`PCW_PORT_F4, data);
        miss_model = 4'd0;
        wait_status(expected_status(vblank, 1'b1, ntsc, miss_model));
        check_bit("int_n", 1'b0, int_n);

        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- pcw_sys_ctrl.f
+incdir+verilog
+incdir+test
verilog/pcw_pkg.sv
verilog/io_bus_if.sv
verilog/page_regs.sv
verilog/sys_ctrl_reg.sv
verilog/mem_mapper.sv
verilog/int_ctrl.sv
verilog/pcw_sys_ctrl.sv
test/tb_pcw_sys_ctrl.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the PCW system-control testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1
log_file=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_pcw_sys_ctrl -f pcw_sys_ctrl.f \
    --Mdir obj_dir -o tb_pcw_sys_ctrl
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_pcw_sys_ctrl > "$log_file" 2>&1
run_status=$?
cat "$log_file"

if grep -q "Test failed" "$log_file"; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
exit 0
